//--- design/usb_rx_pkg.sv
package usb_rx_pkg;

  // PID codes as they appear in the low nibble of the PID byte
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_DATA2 = 4'b0111,
    PID_MDATA = 4'b1111,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_NYET  = 4'b0110,
    PID_PING  = 4'b0100
  } pid_e;

  // The 11 bits after a token PID, address/endpoint or SOF frame number
  typedef union packed {
    struct packed {
      logic [3:0] endp;
      logic [6:0] addr;
    } tok;
    logic [10:0] frame;
  } token_field_u;

  typedef struct packed {
    pid_e         pid;
    token_field_u field;
  } token_s;

  typedef struct packed {
    logic       valid;
    logic       last;
    logic [7:0] data;
  } rx_stream_s;

  typedef struct packed {
    logic strobe;
    logic crc_ok;
    pid_e pid;
  } data_end_s;

  localparam int axil_addr_w = 4;
  localparam int axil_data_w = 32;

  typedef struct packed {
    logic                     aw_valid;
    logic [axil_addr_w-1:0]   aw_addr;
    logic                     w_valid;
    logic [axil_data_w-1:0]   w_data;
    logic [axil_data_w/8-1:0] w_strb;
    logic                     b_ready;
    logic                     ar_valid;
    logic [axil_addr_w-1:0]   ar_addr;
    logic                     r_ready;
  } axil_req_s;

  typedef struct packed {
    logic                   aw_ready;
    logic                   w_ready;
    logic                   b_valid;
    logic [1:0]             b_resp;
    logic                   ar_ready;
    logic                   r_valid;
    logic [axil_data_w-1:0] r_data;
    logic [1:0]             r_resp;
  } axil_rsp_s;

  // Register map
  localparam logic [axil_addr_w-1:0] reg_dev_addr = 4'h0;
  localparam logic [axil_addr_w-1:0] reg_frame    = 4'h4;
  localparam logic [axil_addr_w-1:0] reg_crc_err  = 4'h8;
  localparam logic [axil_addr_w-1:0] reg_pkt_stat = 4'hc;

  // Payload buffer size in bytes
  localparam int buf_depth  = 64;
  localparam int buf_addr_w = $clog2(buf_depth);

  localparam logic [4:0]  crc5_init      = 5'h1f;
  localparam logic [15:0] crc16_init     = 16'hffff;
  localparam logic [15:0] crc16_residue  = 16'h800d;

  // One-hot decoder states
  localparam logic [6:0] st_idle     = 7'h01;
  localparam logic [6:0] st_sof      = 7'h02;
  localparam logic [6:0] st_sof_chk  = 7'h04;
  localparam logic [6:0] st_token    = 7'h08;
  localparam logic [6:0] st_tok_chk  = 7'h10;
  localparam logic [6:0] st_data     = 7'h20;
  localparam logic [6:0] st_data_chk = 7'h40;

  // Serial CRC5 over the token field, bit 0 first, poly x^5 + x^2 + 1
  function automatic logic [4:0] crc5(logic [4:0] crc, logic [10:0] d);
    logic [4:0] c;
    logic       fb;
    c = crc;
    for (int i = 0; i < 11; i++) begin
      fb = c[4] ^ d[i];
      c = {c[3:0], 1'b0};
      if (fb) begin
        c = c ^ 5'h05;
      end
    end
    return c;
  endfunction

  // Serial CRC16 over one byte, bit 0 first, poly 0x8005
  function automatic logic [15:0] crc16(logic [15:0] crc, logic [7:0] d);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      fb = c[15] ^ d[i];
      c = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h8005;
      end
    end
    return c;
  endfunction

endpackage

//--- design/usb_packet_decoder.sv
`timescale 1ns/1ps

module usb_packet_decoder (
  input  logic                   clock,
  input  logic                   reset,
  input  usb_rx_pkg::rx_stream_s rx_i,
  output usb_rx_pkg::token_s     tok_o,
  output logic                   tok_valid_o,
  output logic                   sof_valid_o,
  output logic                   crc_err_o,
  output usb_rx_pkg::rx_stream_s pay_o,
  output usb_rx_pkg::data_end_s  data_end_o,
  output logic                   hsk_valid_o,
  output usb_rx_pkg::pid_e       hsk_pid_o
);

  import usb_rx_pkg::*;

  logic [6:0]   state;
  logic [1:0]   cnt;
  logic [7:0]   buf0;
  logic [7:0]   buf1;
  pid_e         pid_q;
  token_field_u field_q;
  logic [4:0]   crc5_rx_q;
  logic [15:0]  crc16_q;
  logic [15:0]  crc16_next;
  logic [4:0]   crc5_calc;
  logic [4:0]   crc5_exp;
  logic         crc5_ok;
  logic         crc16_ok;
  logic [3:0]   pid_raw;
  logic         pid_ok;
  logic         is_sof;
  logic         is_tok;
  logic         is_data;
  logic         is_hsk;
  logic         data_last;
  logic         tok_valid_q;
  logic         sof_valid_q;
  logic         crc_err_q;
  logic         hsk_valid_q;
  rx_stream_s   pay_q;
  data_end_s    data_end_q;

  // PID byte carries its own complement in the upper nibble
  assign pid_raw = rx_i.data[3:0];
  assign pid_ok  = pid_raw == ~rx_i.data[7:4];
  assign is_sof  = pid_raw == PID_SOF;
  assign is_tok  = (pid_raw[1:0] == 2'b01 && !is_sof) || pid_raw == PID_PING;
  assign is_data = pid_raw[1:0] == 2'b11;
  assign is_hsk  = pid_raw[1:0] == 2'b10;

  assign crc16_next = crc16(crc16_q, rx_i.data);
  assign crc16_ok   = crc16_next == crc16_residue;
  assign data_last  = state == st_data && rx_i.valid && rx_i.last;

  // The CRC5 goes out inverted and MSB first, so flip both ways for the compare
  always_comb begin
    crc5_calc = crc5(crc5_init, field_q.frame);
    for (int i = 0; i < 5; i++) begin
      crc5_exp[i] = ~crc5_calc[4-i];
    end
  end

  assign crc5_ok = crc5_rx_q == crc5_exp;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (rx_i.valid && pid_ok && !rx_i.last) begin
            if (is_sof) begin
              state <= st_sof;
            end else if (is_tok) begin
              state <= st_token;
            end else if (is_data) begin
              state <= st_data;
            end
          end
        end
        // Tokens and SOF are exactly two bytes after the PID
        st_sof: begin
          if (rx_i.valid && rx_i.last) begin
            state <= (cnt == 2'd1) ? st_sof_chk : st_idle;
          end
        end
        st_token: begin
          if (rx_i.valid && rx_i.last) begin
            state <= (cnt == 2'd1) ? st_tok_chk : st_idle;
          end
        end
        st_data: begin
          if (rx_i.valid && rx_i.last) begin
            state <= st_data_chk;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Bytes taken since the PID, saturating at two
  always_ff @(posedge clock) begin
    if (reset) begin
      cnt <= 2'd0;
    end else if (state == st_idle) begin
      cnt <= 2'd0;
    end else if (rx_i.valid && cnt != 2'd2) begin
      cnt <= cnt + 2'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (rx_i.valid) begin
      buf1 <= buf0;
      buf0 <= rx_i.data;
    end
    if (state == st_idle && rx_i.valid && pid_ok) begin
      pid_q   <= pid_e'(pid_raw);
      crc16_q <= crc16_init;
    end
    if (state == st_data && rx_i.valid) begin
      crc16_q <= crc16_next;
    end
    if ((state == st_sof || state == st_token) && rx_i.valid) begin
      if (cnt == 2'd0) begin
        field_q.frame[7:0] <= rx_i.data;
      end else begin
        field_q.frame[10:8] <= rx_i.data[2:0];
        crc5_rx_q           <= rx_i.data[7:3];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_valid_q <= 1'b0;
      sof_valid_q <= 1'b0;
      crc_err_q   <= 1'b0;
      hsk_valid_q <= 1'b0;
      pay_q       <= '0;
      data_end_q  <= '0;
    end else begin
      tok_valid_q <= state == st_tok_chk && crc5_ok;
      sof_valid_q <= state == st_sof_chk && crc5_ok;
      crc_err_q   <= ((state == st_tok_chk || state == st_sof_chk) && !crc5_ok) ||
                     (data_last && !crc16_ok);
      hsk_valid_q <= state == st_idle && rx_i.valid && pid_ok && is_hsk;
      // Payload lags two bytes behind, which leaves the CRC bytes out
      pay_q.valid <= state == st_data && rx_i.valid && cnt == 2'd2;
      pay_q.last  <= rx_i.last;
      pay_q.data  <= buf1;
      data_end_q.strobe <= data_last;
      data_end_q.crc_ok <= crc16_ok && cnt != 2'd0;
      data_end_q.pid    <= pid_q;
    end
  end

  assign tok_o       = '{pid: pid_q, field: field_q};
  assign tok_valid_o = tok_valid_q;
  assign sof_valid_o = sof_valid_q;
  assign crc_err_o   = crc_err_q;
  assign pay_o       = pay_q;
  assign data_end_o  = data_end_q;
  assign hsk_valid_o = hsk_valid_q;
  assign hsk_pid_o   = pid_q;

endmodule

//--- design/usb_token_filter.sv
`timescale 1ns/1ps

module usb_token_filter (
  input  logic               clock,
  input  logic               reset,
  input  logic [6:0]         dev_addr_i,
  input  usb_rx_pkg::token_s tok_i,
  input  logic               tok_valid_i,
  input  logic               sof_valid_i,
  output usb_rx_pkg::token_s tok_o,
  output logic               tok_valid_o,
  output logic [10:0]        frame_o
);

  import usb_rx_pkg::*;

  token_s      tok_q;
  logic        tok_valid_q;
  logic [10:0] frame_q;
  logic        addr_match;

  assign addr_match = tok_i.field.tok.addr == dev_addr_i;

  // Only tokens for this device are passed on
  always_ff @(posedge clock) begin
    if (tok_valid_i && addr_match) begin
      tok_q <= tok_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tok_valid_q <= 1'b0;
      frame_q     <= 11'd0;
    end else begin
      tok_valid_q <= tok_valid_i && addr_match;
      // Same field, read as a frame number on SOF
      if (sof_valid_i) begin
        frame_q <= tok_i.field.frame;
      end
    end
  end

  assign tok_o       = tok_q;
  assign tok_valid_o = tok_valid_q;
  assign frame_o     = frame_q;

endmodule

//--- design/usb_packet_buffer.sv
`timescale 1ns/1ps

module usb_packet_buffer (
  input  logic                   clock,
  input  logic                   reset,
  input  usb_rx_pkg::rx_stream_s pay_i,
  input  usb_rx_pkg::data_end_s  data_end_i,
  output usb_rx_pkg::rx_stream_s data_o,
  input  logic                   data_ready_i,
  output logic                   pkt_commit_o,
  output logic                   pkt_drop_o
);

  import usb_rx_pkg::*;

  // Each entry holds the last flag above the data byte
  logic [8:0]            mem [buf_depth];
  logic [8:0]            rd_word;
  logic [buf_addr_w:0]   rd_ptr;
  logic [buf_addr_w:0]   wr_commit;
  logic [buf_addr_w:0]   wr_spec;
  logic [buf_addr_w:0]   wr_next;
  logic                  full;
  logic                  wr_en;
  logic                  ovf_q;
  logic                  ovf_next;
  logic                  commit_q;
  logic                  drop_q;

  assign full     = (wr_spec - rd_ptr) == (buf_addr_w + 1)'(buf_depth);
  assign wr_en    = pay_i.valid && !full && !ovf_q;
  assign ovf_next = ovf_q || (pay_i.valid && full);
  assign wr_next  = wr_spec + (buf_addr_w + 1)'(wr_en);

  always_ff @(posedge clock) begin
    if (wr_en) begin
      mem[wr_spec[buf_addr_w-1:0]] <= {pay_i.last, pay_i.data};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr    <= '0;
      wr_commit <= '0;
      wr_spec   <= '0;
      ovf_q     <= 1'b0;
      commit_q  <= 1'b0;
      drop_q    <= 1'b0;
    end else begin
      commit_q <= 1'b0;
      drop_q   <= 1'b0;
      if (data_end_i.strobe) begin
        ovf_q <= 1'b0;
        // The final byte may land on the same clock as the end marker
        if (data_end_i.crc_ok && !ovf_next) begin
          wr_commit <= wr_next;
          wr_spec   <= wr_next;
          commit_q  <= 1'b1;
        end else begin
          wr_spec <= wr_commit;
          drop_q  <= 1'b1;
        end
      end else begin
        ovf_q   <= ovf_next;
        wr_spec <= wr_next;
      end
      if (data_o.valid && data_ready_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Only committed bytes are visible downstream
  assign rd_word      = mem[rd_ptr[buf_addr_w-1:0]];
  assign data_o       = '{valid: rd_ptr != wr_commit, last: rd_word[8], data: rd_word[7:0]};
  assign pkt_commit_o = commit_q;
  assign pkt_drop_o   = drop_q;

endmodule

//--- design/usb_rx_csr.sv
`timescale 1ns/1ps

module usb_rx_csr (
  input  logic                  clock,
  input  logic                  reset,
  input  usb_rx_pkg::axil_req_s axil_i,
  output usb_rx_pkg::axil_rsp_s axil_o,
  input  logic [10:0]           frame_i,
  input  logic                  crc_err_i,
  input  logic                  pkt_commit_i,
  input  logic                  pkt_drop_i,
  output logic [6:0]            dev_addr_o
);

  import usb_rx_pkg::*;

  logic                   wr_ready_q;
  logic                   wr_fire;
  logic                   b_valid_q;
  logic                   ar_ready_q;
  logic                   rd_fire;
  logic                   r_valid_q;
  logic [axil_data_w-1:0] r_data_q;
  logic [axil_data_w-1:0] rd_mux;
  logic [6:0]             dev_addr_q;
  logic [15:0]            crc_cnt;
  logic [15:0]            commit_cnt;
  logic [15:0]            drop_cnt;

  function automatic logic [15:0] sat_inc(logic [15:0] v);
    return (v == 16'hffff) ? v : v + 16'd1;
  endfunction

  assign wr_fire = wr_ready_q && axil_i.aw_valid && axil_i.w_valid;
  assign rd_fire = ar_ready_q && axil_i.ar_valid;

  // Handshake side, one transaction in flight per direction
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ready_q <= 1'b0;
      b_valid_q  <= 1'b0;
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
    end else begin
      wr_ready_q <= axil_i.aw_valid && axil_i.w_valid && !wr_ready_q && !b_valid_q;
      if (wr_fire) begin
        b_valid_q <= 1'b1;
      end else if (axil_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      ar_ready_q <= axil_i.ar_valid && !ar_ready_q && !r_valid_q;
      if (rd_fire) begin
        r_valid_q <= 1'b1;
      end else if (axil_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_fire) begin
      r_data_q <= rd_mux;
    end
  end

  always_comb begin
    case (axil_i.ar_addr)
      reg_dev_addr: rd_mux = {25'd0, dev_addr_q};
      reg_frame:    rd_mux = {21'd0, frame_i};
      reg_crc_err:  rd_mux = {16'd0, crc_cnt};
      reg_pkt_stat: rd_mux = {drop_cnt, commit_cnt};
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      dev_addr_q <= 7'd0;
      crc_cnt    <= 16'd0;
      commit_cnt <= 16'd0;
      drop_cnt   <= 16'd0;
    end else begin
      if (wr_fire && axil_i.aw_addr == reg_dev_addr && axil_i.w_strb[0]) begin
        dev_addr_q <= axil_i.w_data[6:0];
      end
      // Any write to CRC_ERR clears the count
      if (wr_fire && axil_i.aw_addr == reg_crc_err) begin
        crc_cnt <= 16'd0;
      end else if (crc_err_i) begin
        crc_cnt <= sat_inc(crc_cnt);
      end
      if (pkt_commit_i) begin
        commit_cnt <= sat_inc(commit_cnt);
      end
      if (pkt_drop_i) begin
        drop_cnt <= sat_inc(drop_cnt);
      end
    end
  end

  always_comb begin
    axil_o          = '0;
    axil_o.aw_ready = wr_ready_q;
    axil_o.w_ready  = wr_ready_q;
    axil_o.b_valid  = b_valid_q;
    axil_o.b_resp   = 2'b00;
    axil_o.ar_ready = ar_ready_q;
    axil_o.r_valid  = r_valid_q;
    axil_o.r_data   = r_data_q;
    axil_o.r_resp   = 2'b00;
  end

  assign dev_addr_o = dev_addr_q;

endmodule

//--- design/usb_rx_top.sv
`timescale 1ns/1ps

module usb_rx_top (
  input  logic                   clock,
  input  logic                   reset,
  input  usb_rx_pkg::rx_stream_s rx_i,
  output usb_rx_pkg::rx_stream_s data_o,
  input  logic                   data_ready_i,
  output usb_rx_pkg::token_s     tok_o,
  output logic                   tok_valid_o,
  output logic                   hsk_valid_o,
  output usb_rx_pkg::pid_e       hsk_pid_o,
  input  usb_rx_pkg::axil_req_s  axil_i,
  output usb_rx_pkg::axil_rsp_s  axil_o
);

  import usb_rx_pkg::*;

  token_s      tok;
  logic        tok_valid;
  logic        sof_valid;
  logic        crc_err;
  rx_stream_s  pay;
  data_end_s   data_end;
  logic [6:0]  dev_addr;
  logic [10:0] frame;
  logic        pkt_commit;
  logic        pkt_drop;

  usb_packet_decoder i_decoder (
    .clock       (clock),
    .reset       (reset),
    .rx_i        (rx_i),
    .tok_o       (tok),
    .tok_valid_o (tok_valid),
    .sof_valid_o (sof_valid),
    .crc_err_o   (crc_err),
    .pay_o       (pay),
    .data_end_o  (data_end),
    .hsk_valid_o (hsk_valid_o),
    .hsk_pid_o   (hsk_pid_o)
  );

  usb_token_filter i_filter (
    .clock       (clock),
    .reset       (reset),
    .dev_addr_i  (dev_addr),
    .tok_i       (tok),
    .tok_valid_i (tok_valid),
    .sof_valid_i (sof_valid),
    .tok_o       (tok_o),
    .tok_valid_o (tok_valid_o),
    .frame_o     (frame)
  );

  usb_packet_buffer i_buffer (
    .clock        (clock),
    .reset        (reset),
    .pay_i        (pay),
    .data_end_i   (data_end),
    .data_o       (data_o),
    .data_ready_i (data_ready_i),
    .pkt_commit_o (pkt_commit),
    .pkt_drop_o   (pkt_drop)
  );

  usb_rx_csr i_csr (
    .clock        (clock),
    .reset        (reset),
    .axil_i       (axil_i),
    .axil_o       (axil_o),
    .frame_i      (frame),
    .crc_err_i    (crc_err),
    .pkt_commit_i (pkt_commit),
    .pkt_drop_i   (pkt_drop),
    .dev_addr_o   (dev_addr)
  );

endmodule

//--- verif/usb_rx_tb.sv
`timescale 1ns/1ps

module usb_rx_tb;

  import usb_rx_pkg::*;

  localparam int clk_period  = 10;
  localparam int n_rand_pkts = 40;
  localparam int max_len     = 24;
  localparam int max_gap     = 2;
  localparam int ovf_len     = 20;
  localparam int axi_limit   = 32;
  localparam int drain_limit = 2000;
  localparam int worst_bytes = n_rand_pkts * (max_len + 3) + 5 * (ovf_len + 3) + 16 * 3;
  localparam int wd_cycles   = 2 * worst_bytes * (max_gap + 1) + 3000;
  localparam pid_e data_pids [4] = '{PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA};
  localparam pid_e hsk_pids [4]  = '{PID_ACK, PID_NAK, PID_STALL, PID_NYET};

  logic       clock;
  logic       reset;
  rx_stream_s rx;
  rx_stream_s data_out;
  logic       data_ready;
  token_s     tok_out;
  logic       tok_valid;
  logic       hsk_valid;
  pid_e       hsk_pid;
  axil_req_s  axil_req;
  axil_rsp_s  axil_rsp;

  logic       tok_mark;
  logic       hsk_mark;
  logic [2:0] tok_pipe;
  logic       hsk_pipe;
  token_s     exp_tok;
  pid_e       exp_hsk;
  logic [1:0] ready_mode;
  logic [7:0] tx_q[$];
  logic [8:0] out_q[$];
  string      test_name;
  int         value_errors;
  int         other_errors;
  int         exp_crc_err;
  int         exp_commit;
  int         exp_drop;

  usb_rx_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .rx_i         (rx),
    .data_o       (data_out),
    .data_ready_i (data_ready),
    .tok_o        (tok_out),
    .tok_valid_o  (tok_valid),
    .hsk_valid_o  (hsk_valid),
    .hsk_pid_o    (hsk_pid),
    .axil_i       (axil_req),
    .axil_o       (axil_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    value_errors++;
    $display("** Error %s (%s): expected %h, actual %h", test_name, what, expected, actual);
  endtask

  task automatic report_failure(input string msg);
    other_errors++;
    $display("Failure in %s: %s", test_name, msg);
  endtask

  // Reflected CRC5 giving the five bits as they sit in the second token byte
  function automatic logic [4:0] token_crc5(input logic [10:0] field);
    logic [4:0] r;
    r = 5'h1f;
    for (int i = 0; i < 11; i++) begin
      if (r[0] ^ field[i]) begin
        r = (r >> 1) ^ 5'h14;
      end else begin
        r = r >> 1;
      end
    end
    return ~r;
  endfunction

  // Reflected CRC16 step over one byte
  // The complement of the final value goes out low byte first
  function automatic logic [15:0] data_crc16_byte(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] r;
    r = crc;
    for (int i = 0; i < 8; i++) begin
      if (r[0] ^ b[i]) begin
        r = (r >> 1) ^ 16'ha001;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  function automatic logic [7:0] pid_byte(input pid_e p);
    return {~p, p};
  endfunction

  // Matching token strobe lags the last byte by three clocks
  always @(posedge clock) begin
    tok_pipe <= {tok_pipe[1:0], tok_mark};
    hsk_pipe <= hsk_mark;
  end

  always @(posedge clock) begin
    case (ready_mode)
      2'd0:    data_ready <= 1'b1;
      2'd1:    data_ready <= ($urandom % 4) != 0;
      default: data_ready <= 1'b0;
    endcase
  end

  always @(posedge clock) begin : out_monitor
    logic [8:0] exp_byte;
    if (!reset && data_out.valid && data_ready) begin
      if (out_q.size() == 0) begin
        report_failure($sformatf("data_o gave byte %h with no packet pending", data_out.data));
      end else begin
        exp_byte = out_q.pop_front();
        assert ({data_out.last, data_out.data} == exp_byte)
          else report_mismatch("data_o", 32'(exp_byte), 32'({data_out.last, data_out.data}));
      end
    end
  end

  tok_strobe_a: assert property (@(posedge clock) disable iff (reset)
    tok_valid == tok_pipe[2])
    else report_mismatch("tok_valid_o", 32'($sampled(tok_pipe[2])), 32'($sampled(tok_valid)));

  tok_value_a: assert property (@(posedge clock) disable iff (reset)
    tok_valid |-> tok_out == exp_tok)
    else report_mismatch("tok_o", 32'($sampled(exp_tok)), 32'($sampled(tok_out)));

  hsk_strobe_a: assert property (@(posedge clock) disable iff (reset)
    hsk_valid == hsk_pipe)
    else report_mismatch("hsk_valid_o", 32'($sampled(hsk_pipe)), 32'($sampled(hsk_valid)));

  hsk_value_a: assert property (@(posedge clock) disable iff (reset)
    hsk_valid |-> hsk_pid == exp_hsk)
    else report_mismatch("hsk_pid_o", 32'($sampled(exp_hsk)), 32'($sampled(hsk_pid)));

  out_stable_a: assert property (@(posedge clock) disable iff (reset)
    data_out.valid && !data_ready |=> $stable(data_out))
    else report_failure("data_o changed while data_ready_i was low");

  aw_w_ready_a: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.aw_ready == axil_rsp.w_ready)
    else report_failure("aw_ready and w_ready were not raised together");

  b_hold_a: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid)
    else report_failure("b_valid fell before b_ready was given");

  b_resp_a: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.b_valid |-> axil_rsp.b_resp == 2'b00)
    else report_mismatch("b_resp", 32'd0, 32'($sampled(axil_rsp.b_resp)));

  r_hold_a: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data))
    else report_failure("r_valid or r_data changed before r_ready was given");

  r_resp_a: assert property (@(posedge clock) disable iff (reset)
    axil_rsp.r_valid |-> axil_rsp.r_resp == 2'b00)
    else report_mismatch("r_resp", 32'd0, 32'($sampled(axil_rsp.r_resp)));

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge clock);
    axil_req.aw_valid <= 1'b1;
    axil_req.aw_addr  <= addr;
    axil_req.w_valid  <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= 4'hf;
    @(posedge clock);
    while (!axil_rsp.aw_ready && n < axi_limit) begin
      @(posedge clock);
      n++;
    end
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    while (!axil_rsp.b_valid && n < axi_limit) begin
      @(posedge clock);
      n++;
    end
    if (n >= axi_limit) begin
      report_failure($sformatf("AXI4-Lite write to offset %h got no response", addr));
    end
    repeat ($urandom % 3) @(posedge clock);
    axil_req.b_ready <= 1'b1;
    @(posedge clock);
    axil_req.b_ready <= 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge clock);
    axil_req.ar_valid <= 1'b1;
    axil_req.ar_addr  <= addr;
    @(posedge clock);
    while (!axil_rsp.ar_ready && n < axi_limit) begin
      @(posedge clock);
      n++;
    end
    axil_req.ar_valid <= 1'b0;
    while (!axil_rsp.r_valid && n < axi_limit) begin
      @(posedge clock);
      n++;
    end
    data = axil_rsp.r_data;
    if (n >= axi_limit) begin
      report_failure($sformatf("AXI4-Lite read of offset %h got no response", addr));
    end
    repeat ($urandom % 3) @(posedge clock);
    axil_req.r_ready <= 1'b1;
    @(posedge clock);
    axil_req.r_ready <= 1'b0;
  endtask

  task automatic check_reg(input string name, input logic [3:0] addr,
                           input logic [31:0] expected);
    logic [31:0] value;
    axil_read(addr, value);
    assert (value == expected) else report_mismatch(name, expected, value);
  endtask

  // Plays out tx_q, optionally with idle cycles between bytes
  task automatic send_packet(input logic gaps, input logic mark_tok, input logic mark_hsk);
    int n;
    n = tx_q.size();
    for (int i = 0; i < n; i++) begin
      if (gaps && i > 0) begin
        repeat ($urandom % (max_gap + 1)) begin
          @(posedge clock);
          rx.valid <= 1'b0;
        end
      end
      @(posedge clock);
      rx <= '{valid: 1'b1, last: (i == n - 1), data: tx_q[i]};
      if (i == n - 1) begin
        tok_mark <= mark_tok;
        hsk_mark <= mark_hsk;
      end
    end
    @(posedge clock);
    rx       <= '0;
    tok_mark <= 1'b0;
    hsk_mark <= 1'b0;
    repeat (5) @(posedge clock);
    tx_q.delete();
  endtask

  task automatic build_token(input pid_e pid, input logic [10:0] field, input logic corrupt);
    logic [7:0] b1;
    b1 = {token_crc5(field), field[10:8]};
    if (corrupt) begin
      b1 = b1 ^ 8'h80;
    end
    tx_q.push_back(pid_byte(pid));
    tx_q.push_back(field[7:0]);
    tx_q.push_back(b1);
  endtask

  task automatic send_token(input pid_e pid, input logic [6:0] addr, input logic [3:0] endp,
                            input logic corrupt, input logic hit);
    if (hit) begin
      exp_tok.pid              = pid;
      exp_tok.field.tok.addr   = addr;
      exp_tok.field.tok.endp   = endp;
    end
    build_token(pid, {endp, addr}, corrupt);
    send_packet(1'b1, hit, 1'b0);
  endtask

  task automatic build_data(input pid_e pid, input int len, input logic corrupt,
                            input logic expect_out);
    logic [15:0] r;
    logic [7:0]  b;
    r = 16'hffff;
    tx_q.push_back(pid_byte(pid));
    for (int i = 0; i < len; i++) begin
      b = 8'($urandom);
      r = data_crc16_byte(r, b);
      tx_q.push_back(b);
      if (expect_out) begin
        out_q.push_back({i == len - 1, b});
      end
    end
    if (corrupt) begin
      tx_q[1] = tx_q[1] ^ 8'h01;
    end
    tx_q.push_back(~r[7:0]);
    tx_q.push_back(~r[15:8]);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (out_q.size() != 0 && n < drain_limit) begin
      @(posedge clock);
      n++;
    end
    if (out_q.size() != 0) begin
      report_failure($sformatf("%0d expected bytes never left data_o", out_q.size()));
    end
  endtask

  initial begin
    repeat (wd_cycles) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : main
    logic [10:0] frame;
    logic [6:0]  dev;
    int          len;
    void'($urandom(74855));
    rx           <= '0;
    data_ready   <= 1'b0;
    axil_req     <= '0;
    tok_mark     <= 1'b0;
    hsk_mark     <= 1'b0;
    reset        <= 1'b1;
    exp_tok      = '0;
    exp_hsk      = PID_ACK;
    ready_mode   = 2'd0;
    value_errors = 0;
    other_errors = 0;
    exp_crc_err  = 0;
    exp_commit   = 0;
    exp_drop     = 0;
    test_name    = "reset";
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    check_reg("DEV_ADDR", reg_dev_addr, 32'd0);
    check_reg("FRAME", reg_frame, 32'd0);
    check_reg("CRC_ERR", reg_crc_err, 32'd0);
    check_reg("PKT_STAT", reg_pkt_stat, 32'd0);

    test_name = "token_filter";
    dev = 7'h2a;
    axil_write(reg_dev_addr, 32'(dev));
    check_reg("DEV_ADDR", reg_dev_addr, 32'(dev));
    send_token(PID_IN, dev, 4'd3, 1'b0, 1'b1);
    send_token(PID_OUT, dev, 4'd1, 1'b0, 1'b1);
    send_token(PID_SETUP, dev, 4'd0, 1'b0, 1'b1);
    send_token(PID_IN, 7'h15, 4'd3, 1'b0, 1'b0);

    test_name = "sof_frame";
    repeat (2) begin
      frame = 11'($urandom);
      build_token(PID_SOF, frame, 1'b0);
      send_packet(1'b1, 1'b0, 1'b0);
      check_reg("FRAME", reg_frame, 32'(frame));
    end

    test_name = "crc_error";
    send_token(PID_OUT, dev, 4'd2, 1'b1, 1'b0);
    exp_crc_err++;
    build_token(PID_SOF, ~frame, 1'b1);
    send_packet(1'b1, 1'b0, 1'b0);
    exp_crc_err++;
    check_reg("FRAME", reg_frame, 32'(frame));
    build_data(PID_DATA0, 8, 1'b1, 1'b0);
    send_packet(1'b1, 1'b0, 1'b0);
    exp_crc_err++;
    exp_drop++;
    check_reg("CRC_ERR", reg_crc_err, 32'(exp_crc_err));
    axil_write(reg_crc_err, 32'h0);
    exp_crc_err = 0;
    check_reg("CRC_ERR", reg_crc_err, 32'd0);
    check_reg("PKT_STAT", reg_pkt_stat, {16'(exp_drop), 16'(exp_commit)});

    test_name = "random_data";
    ready_mode = 2'd1;
    repeat (n_rand_pkts) begin
      len = 1 + int'($urandom % max_len);
      build_data(data_pids[$urandom % 4], len, 1'b0, 1'b1);
      send_packet(1'b1, 1'b0, 1'b0);
      exp_commit++;
    end
    wait_drain();
    check_reg("PKT_STAT", reg_pkt_stat, {16'(exp_drop), 16'(exp_commit)});

    // Three packets fill 60 of 64 bytes and the next two cannot fit
    test_name = "overflow";
    ready_mode = 2'd2;
    repeat (3) @(posedge clock);
    repeat (3) begin
      build_data(PID_DATA1, ovf_len, 1'b0, 1'b1);
      send_packet(1'b1, 1'b0, 1'b0);
      exp_commit++;
    end
    repeat (2) begin
      build_data(PID_DATA0, ovf_len, 1'b0, 1'b0);
      send_packet(1'b1, 1'b0, 1'b0);
      exp_drop++;
    end
    check_reg("PKT_STAT", reg_pkt_stat, {16'(exp_drop), 16'(exp_commit)});
    ready_mode = 2'd1;
    wait_drain();

    test_name = "handshake";
    for (int i = 0; i < 4; i++) begin
      exp_hsk = hsk_pids[i];
      tx_q.push_back(pid_byte(hsk_pids[i]));
      send_packet(1'b0, 1'b0, 1'b1);
    end
    // Upper nibble not the complement, so these bytes must be ignored
    tx_q.push_back(8'h22);
    send_packet(1'b0, 1'b0, 1'b0);
    tx_q.push_back(8'h33);
    repeat (4) tx_q.push_back(8'h00);
    send_packet(1'b1, 1'b0, 1'b0);
    check_reg("CRC_ERR", reg_crc_err, 32'(exp_crc_err));
    check_reg("PKT_STAT", reg_pkt_stat, {16'(exp_drop), 16'(exp_commit)});
    repeat (10) @(posedge clock);

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
design/usb_rx_pkg.sv
design/usb_packet_decoder.sv
design/usb_token_filter.sv
design/usb_packet_buffer.sv
design/usb_rx_csr.sv
design/usb_rx_top.sv
verif/usb_rx_tb.sv

//--- Bender.yml
package:
  name: usb_rx

sources:
  - design/usb_rx_pkg.sv
  - design/usb_packet_decoder.sv
  - design/usb_token_filter.sv
  - design/usb_packet_buffer.sv
  - design/usb_rx_csr.sv
  - design/usb_rx_top.sv
  - target: test
    files:
      - verif/usb_rx_tb.sv
